// ==== hdl/excl_pkg.sv ====
package excl_pkg;

    // Byte address, data and strobe widths of every channel
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // Transaction ID carried through to the response
    localparam int ID_W = 4;

    // Memory depth in words, byte addresses 0 to 1023
    localparam int MEM_WORDS = 256;

    // Word index width and the byte offset bits below it
    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int WORD_LSB = $clog2(STRB_W);

    // AXI response encodings
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    // Read request, single beat
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic              lock;
    } rd_req_t;

    // Read response
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_t             resp;
    } rd_rsp_t;

    // Write request, address and data in one beat
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              lock;
    } wr_req_t;

    // Write response
    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_t           resp;
    } wr_rsp_t;

endpackage

// ==== hdl/txn_arbiter.sv ====
module txn_arbiter
    import excl_pkg::*;
#(
    parameter type req_t = rd_req_t,
    parameter type rsp_t = rd_rsp_t
) (
    input  logic       clk,
    input  logic       rst_n,
    // Master side, index 0 is m0
    input  logic [1:0] req_valid,
    output logic [1:0] req_ready,
    input  req_t [1:0] req,
    output logic [1:0] rsp_valid,
    input  logic [1:0] rsp_ready,
    output rsp_t [1:0] rsp,
    // Downstream side toward the monitor
    output logic       out_valid,
    input  logic       out_ready,
    output req_t       out_req,
    input  logic       in_valid,
    output logic       in_ready,
    input  rsp_t       in_rsp
);

    // Transaction in flight, waiting for its response
    logic busy;
    // Master that owns the transaction in flight
    logic owner;
    // Master with priority at the next arbitration
    logic prio;
    // Master selected this cycle
    logic pick;

    // Priority master wins if valid, otherwise the other one
    assign pick = req_valid[prio] ? prio : ~prio;

    // Nothing is offered downstream while a response is pending
    assign out_valid = !busy && (req_valid != 2'b00);
    assign out_req = req[pick];

    always_comb begin
        req_ready = 2'b00;
        rsp_valid = 2'b00;
        // Only the selected master sees ready
        req_ready[pick] = out_valid && out_ready;
        // Response steered to the owner
        rsp_valid[owner] = busy && in_valid;
    end

    assign in_ready = busy && rsp_ready[owner];

    // Payload goes to both, rsp_valid picks the receiver
    assign rsp = {in_rsp, in_rsp};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
        end else if (out_valid && out_ready) begin
            busy  <= 1'b1;
            owner <= pick;
        end else if (in_valid && in_ready) begin
            busy <= 1'b0;
            // Hand priority to the other master after each response
            prio <= ~owner;
        end else if (out_valid) begin
            // Stalled request keeps the selection until it is taken
            prio <= pick;
        end
    end

endmodule

// ==== hdl/exclusive_monitor.sv ====
module exclusive_monitor
    import excl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Read side
    input  logic              rd_valid,
    output logic              rd_ready,
    input  rd_req_t           rd,
    output logic              rd_rsp_valid,
    input  logic              rd_rsp_ready,
    output rd_rsp_t           rd_rsp,
    // Write side
    input  logic              wr_valid,
    output logic              wr_ready,
    input  wr_req_t           wr,
    output logic              wr_rsp_valid,
    input  logic              wr_rsp_ready,
    output wr_rsp_t           wr_rsp,
    // Memory side, shared by reads and writes
    output logic              mem_valid,
    input  logic              mem_ready,
    output logic              mem_we,
    output wr_req_t           mem_req,
    input  logic              mem_rsp_valid,
    output logic              mem_rsp_ready,
    input  logic [DATA_W-1:0] mem_rsp_data,
    input  resp_t             mem_rsp_resp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t state;

    // Single reservation
    logic              res_valid;
    logic [ADDR_W-1:0] res_addr;
    logic [ID_W-1:0]   res_id;

    // Context of the transaction in flight
    logic [ADDR_W-1:0] cur_addr;
    logic [ID_W-1:0]   cur_id;
    logic              cur_promote;
    logic              cur_clear;

    logic  wr_hit;
    logic  wr_excl_ok;
    logic  rd_acc;
    logic  wr_acc;
    logic  rsp_done;
    resp_t rsp_code;

    // Write lands in the reserved word
    assign wr_hit = res_valid &&
                    (wr.addr[ADDR_W-1:WORD_LSB] == res_addr[ADDR_W-1:WORD_LSB]);
    // Exclusive write passes only with matching address and ID
    assign wr_excl_ok = wr.lock && wr_hit && (wr.id == res_id);

    // Writes win over reads in idle
    assign wr_ready = (state == ST_IDLE) && mem_ready;
    assign rd_ready = (state == ST_IDLE) && !wr_valid && mem_ready;
    assign mem_valid = (state == ST_IDLE) && (wr_valid || rd_valid);
    assign mem_we = wr_valid;

    assign wr_acc = wr_valid && wr_ready;
    assign rd_acc = rd_valid && rd_ready;

    always_comb begin
        if (wr_valid) begin
            mem_req = wr;
            // Failed exclusive write reaches memory with no byte enabled
            if (wr.lock && !wr_excl_ok) begin
                mem_req.strb = '0;
            end
        end else begin
            mem_req.id   = rd.id;
            mem_req.addr = rd.addr;
            mem_req.data = '0;
            mem_req.strb = '0;
            mem_req.lock = rd.lock;
        end
    end

    // Response path follows the state that issued the request
    assign rd_rsp_valid = (state == ST_READ) && mem_rsp_valid;
    assign wr_rsp_valid = (state == ST_WRITE) && mem_rsp_valid;
    assign mem_rsp_ready = ((state == ST_READ) && rd_rsp_ready) ||
                           ((state == ST_WRITE) && wr_rsp_ready);
    assign rsp_done = mem_rsp_valid && mem_rsp_ready;

    // OKAY becomes EXOKAY for a successful exclusive, errors pass unchanged
    assign rsp_code = (mem_rsp_resp == RESP_OKAY && cur_promote) ? RESP_EXOKAY : mem_rsp_resp;

    assign rd_rsp = '{id: cur_id, data: mem_rsp_data, resp: rsp_code};
    assign wr_rsp = '{id: cur_id, resp: rsp_code};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            res_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_acc) begin
                        state <= ST_WRITE;
                    end else if (rd_acc) begin
                        state <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (rsp_done) begin
                        state <= ST_IDLE;
                        // Locked read takes the reservation
                        if (cur_promote && mem_rsp_resp == RESP_OKAY) begin
                            res_valid <= 1'b1;
                        end
                    end
                end
                ST_WRITE: begin
                    if (rsp_done) begin
                        state <= ST_IDLE;
                        // Store-conditional success or plain write to reserved word
                        if (cur_clear && mem_rsp_resp == RESP_OKAY) begin
                            res_valid <= 1'b0;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Reservation address and ID follow the locked read on success
    always_ff @(posedge clk) begin
        if (state == ST_READ && rsp_done && cur_promote && mem_rsp_resp == RESP_OKAY) begin
            res_addr <= cur_addr;
            res_id   <= cur_id;
        end
    end

    // Capture the request context at acceptance
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            cur_addr    <= wr.addr;
            cur_id      <= wr.id;
            cur_promote <= wr_excl_ok;
            cur_clear   <= wr_excl_ok || (!wr.lock && wr_hit);
        end else if (rd_acc) begin
            cur_addr    <= rd.addr;
            cur_id      <= rd.id;
            cur_promote <= rd.lock;
            cur_clear   <= 1'b0;
        end
    end

endmodule

// ==== hdl/sram_target.sv ====
module sram_target
    import excl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Request
    input  logic              mem_valid,
    output logic              mem_ready,
    input  logic              mem_we,
    input  wr_req_t           mem_req,
    // Registered response
    output logic              mem_rsp_valid,
    input  logic              mem_rsp_ready,
    output logic [DATA_W-1:0] mem_rsp_data,
    output resp_t             mem_rsp_resp
);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic              accept;
    logic              in_range;
    logic [MEM_AW-1:0] idx;

    // New request only when no response is held
    assign mem_ready = !mem_rsp_valid;
    assign accept = mem_valid && mem_ready;

    // Word index from the byte address
    assign idx = mem_req.addr[WORD_LSB +: MEM_AW];

    // Bits above the word index must be zero
    assign in_range = (mem_req.addr[ADDR_W-1:WORD_LSB+MEM_AW] == '0);

    // Response valid and held until taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rsp_valid <= 1'b0;
        end else if (accept) begin
            mem_rsp_valid <= 1'b1;
        end else if (mem_rsp_ready) begin
            mem_rsp_valid <= 1'b0;
        end
    end

    // Response payload, loaded once per accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            if (!in_range) begin
                mem_rsp_resp <= RESP_DECERR;
                mem_rsp_data <= '0;
            end else begin
                mem_rsp_resp <= RESP_OKAY;
                // Writes return no data
                mem_rsp_data <= mem_we ? '0 : mem[idx];
            end
        end
    end

    // Byte lanes written under their strobes
    always_ff @(posedge clk) begin
        if (accept && mem_we && in_range) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (mem_req.strb[b]) begin
                    mem[idx][8*b +: 8] <= mem_req.data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/excl_mem_top.sv ====
module excl_mem_top
    import excl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // Master 0
    input  logic    m0_rd_req_valid,
    output logic    m0_rd_req_ready,
    input  rd_req_t m0_rd_req,
    output logic    m0_rd_rsp_valid,
    input  logic    m0_rd_rsp_ready,
    output rd_rsp_t m0_rd_rsp,
    input  logic    m0_wr_req_valid,
    output logic    m0_wr_req_ready,
    input  wr_req_t m0_wr_req,
    output logic    m0_wr_rsp_valid,
    input  logic    m0_wr_rsp_ready,
    output wr_rsp_t m0_wr_rsp,
    // Master 1
    input  logic    m1_rd_req_valid,
    output logic    m1_rd_req_ready,
    input  rd_req_t m1_rd_req,
    output logic    m1_rd_rsp_valid,
    input  logic    m1_rd_rsp_ready,
    output rd_rsp_t m1_rd_rsp,
    input  logic    m1_wr_req_valid,
    output logic    m1_wr_req_ready,
    input  wr_req_t m1_wr_req,
    output logic    m1_wr_rsp_valid,
    input  logic    m1_wr_rsp_ready,
    output wr_rsp_t m1_wr_rsp
);

    // Granted read stream
    logic    rd_valid;
    logic    rd_ready;
    rd_req_t rd;
    logic    rd_rsp_valid;
    logic    rd_rsp_ready;
    rd_rsp_t rd_rsp;

    // Granted write stream
    logic    wr_valid;
    logic    wr_ready;
    wr_req_t wr;
    logic    wr_rsp_valid;
    logic    wr_rsp_ready;
    wr_rsp_t wr_rsp;

    // Monitor to SRAM
    logic              mem_valid;
    logic              mem_ready;
    logic              mem_we;
    wr_req_t           mem_req;
    logic              mem_rsp_valid;
    logic              mem_rsp_ready;
    logic [DATA_W-1:0] mem_rsp_data;
    resp_t             mem_rsp_resp;

    txn_arbiter #(
        .req_t (rd_req_t),
        .rsp_t (rd_rsp_t)
    ) i_rd_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid ({m1_rd_req_valid, m0_rd_req_valid}),
        .req_ready ({m1_rd_req_ready, m0_rd_req_ready}),
        .req       ({m1_rd_req, m0_rd_req}),
        .rsp_valid ({m1_rd_rsp_valid, m0_rd_rsp_valid}),
        .rsp_ready ({m1_rd_rsp_ready, m0_rd_rsp_ready}),
        .rsp       ({m1_rd_rsp, m0_rd_rsp}),
        .out_valid (rd_valid),
        .out_ready (rd_ready),
        .out_req   (rd),
        .in_valid  (rd_rsp_valid),
        .in_ready  (rd_rsp_ready),
        .in_rsp    (rd_rsp)
    );

    txn_arbiter #(
        .req_t (wr_req_t),
        .rsp_t (wr_rsp_t)
    ) i_wr_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid ({m1_wr_req_valid, m0_wr_req_valid}),
        .req_ready ({m1_wr_req_ready, m0_wr_req_ready}),
        .req       ({m1_wr_req, m0_wr_req}),
        .rsp_valid ({m1_wr_rsp_valid, m0_wr_rsp_valid}),
        .rsp_ready ({m1_wr_rsp_ready, m0_wr_rsp_ready}),
        .rsp       ({m1_wr_rsp, m0_wr_rsp}),
        .out_valid (wr_valid),
        .out_ready (wr_ready),
        .out_req   (wr),
        .in_valid  (wr_rsp_valid),
        .in_ready  (wr_rsp_ready),
        .in_rsp    (wr_rsp)
    );

    exclusive_monitor i_monitor (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd            (rd),
        .rd_rsp_valid  (rd_rsp_valid),
        .rd_rsp_ready  (rd_rsp_ready),
        .rd_rsp        (rd_rsp),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr            (wr),
        .wr_rsp_valid  (wr_rsp_valid),
        .wr_rsp_ready  (wr_rsp_ready),
        .wr_rsp        (wr_rsp),
        .mem_valid     (mem_valid),
        .mem_ready     (mem_ready),
        .mem_we        (mem_we),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_resp  (mem_rsp_resp)
    );

    sram_target i_sram (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_valid     (mem_valid),
        .mem_ready     (mem_ready),
        .mem_we        (mem_we),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_resp  (mem_rsp_resp)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk
);

    // Free running clock with a period of 8 time units
    initial begin
        clk = 1'b0;
        forever begin
            // Half period
            #4 clk = ~clk;
        end
    end

endmodule

// ==== bench/excl_mem_sva.sv ====
module excl_mem_sva
    import excl_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              rd_valid,
    input logic              rd_ready,
    input rd_req_t           rd,
    input logic              wr_valid,
    input logic              wr_ready,
    input wr_req_t           wr,
    input logic              rd_rsp_valid,
    input logic              wr_rsp_valid,
    input logic              mem_valid,
    input logic              mem_we,
    input wr_req_t           mem_req,
    input logic              res_valid,
    input logic [ADDR_W-1:0] res_addr,
    input logic [ID_W-1:0]   res_id
);

    // Number of failed assertions, read by the testbench at the end
    int fail_cnt = 0;

    // Locked write that misses the reservation or carries another ID
    logic excl_fail;
    assign excl_fail = wr.lock && !(res_valid && (wr.id == res_id) &&
                       (wr.addr[ADDR_W-1:WORD_LSB] == res_addr[ADDR_W-1:WORD_LSB]));

    // Requests hold still until accepted
    rd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd))
    else begin
        $error("Read request changed while waiting for ready");
        fail_cnt++;
    end

    wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr))
    else begin
        $error("Write request changed while waiting for ready");
        fail_cnt++;
    end

    // Failed exclusive write reaches the SRAM with every byte disabled
    masked_write: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && mem_we && excl_fail |-> mem_req.strb == '0)
    else begin
        $error("Failed exclusive write reached memory with strobes set");
        fail_cnt++;
    end

    // No response is offered in the first cycle out of reset
    quiet_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !rd_rsp_valid && !wr_rsp_valid)
    else begin
        $error("Response valid high right after reset");
        fail_cnt++;
    end

endmodule

bind exclusive_monitor excl_mem_sva i_sva (.*);

// ==== bench/excl_mem_tb.sv ====
module excl_mem_tb
    import excl_pkg::*;
();

    logic clk;
    logic rst_n;

    // Channels toward the DUT, index is the master number
    logic [1:0] rd_req_valid;
    logic [1:0] rd_req_ready;
    rd_req_t    rd_req [2];
    logic [1:0] rd_rsp_valid;
    logic [1:0] rd_rsp_ready;
    rd_rsp_t    rd_rsp [2];
    logic [1:0] wr_req_valid;
    logic [1:0] wr_req_ready;
    wr_req_t    wr_req [2];
    logic [1:0] wr_rsp_valid;
    logic [1:0] wr_rsp_ready;
    wr_rsp_t    wr_rsp [2];

    // Trace contents, one entry per transaction
    string             t_name [$];
    int                t_master [$];
    logic              t_is_wr [$];
    logic              t_lock [$];
    logic [ADDR_W-1:0] t_addr [$];
    logic [DATA_W-1:0] t_wdata [$];
    logic [STRB_W-1:0] t_strb [$];
    logic [1:0]        t_resp [$];
    logic [DATA_W-1:0] t_rdata [$];
    logic              t_pair [$];
    // Order in which responses completed
    int                t_arrival [$];

    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int arrival_seq = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    tb_clock_gen i_clk (.clk(clk));

    excl_mem_top i_excl_mem_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .m0_rd_req_valid (rd_req_valid[0]),
        .m0_rd_req_ready (rd_req_ready[0]),
        .m0_rd_req       (rd_req[0]),
        .m0_rd_rsp_valid (rd_rsp_valid[0]),
        .m0_rd_rsp_ready (rd_rsp_ready[0]),
        .m0_rd_rsp       (rd_rsp[0]),
        .m0_wr_req_valid (wr_req_valid[0]),
        .m0_wr_req_ready (wr_req_ready[0]),
        .m0_wr_req       (wr_req[0]),
        .m0_wr_rsp_valid (wr_rsp_valid[0]),
        .m0_wr_rsp_ready (wr_rsp_ready[0]),
        .m0_wr_rsp       (wr_rsp[0]),
        .m1_rd_req_valid (rd_req_valid[1]),
        .m1_rd_req_ready (rd_req_ready[1]),
        .m1_rd_req       (rd_req[1]),
        .m1_rd_rsp_valid (rd_rsp_valid[1]),
        .m1_rd_rsp_ready (rd_rsp_ready[1]),
        .m1_rd_rsp       (rd_rsp[1]),
        .m1_wr_req_valid (wr_req_valid[1]),
        .m1_wr_req_ready (wr_req_ready[1]),
        .m1_wr_req       (wr_req[1]),
        .m1_wr_rsp_valid (wr_rsp_valid[1]),
        .m1_wr_rsp_ready (wr_rsp_ready[1]),
        .m1_wr_rsp       (wr_rsp[1])
    );

    // AXI response names for the log
    function automatic string resp_name(input logic [1:0] r);
        case (r)
            2'b00: return "OKAY";
            2'b01: return "EXOKAY";
            2'b10: return "SLVERR";
            2'b11: return "DECERR";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_trace();
        int fd;
        int n;
        int code;
        int master;
        int lock;
        int pair;
        string line;
        string name;
        string op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] strb;
        logic [31:0] resp;
        logic [31:0] rdata;
        fd = $fopen("bench/excl_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/excl_trace.txt");
            err_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip comment lines
            if (code == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %s %d %h %h %h %h %h %d", name, master, op, lock,
                        addr, wdata, strb, resp, rdata, pair);
            if (n <= 0) begin
                continue;
            end
            if (n != 10 || (op != "rd" && op != "wr") || master < 0 || master > 1) begin
                $display("Malformed trace line: %s", line);
                err_cnt++;
                continue;
            end
            t_name.push_back(name);
            t_master.push_back(master);
            t_is_wr.push_back(op == "wr");
            t_lock.push_back(lock != 0);
            t_addr.push_back(addr[ADDR_W-1:0]);
            t_wdata.push_back(wdata);
            t_strb.push_back(strb[STRB_W-1:0]);
            t_resp.push_back(resp[1:0]);
            t_rdata.push_back(rdata);
            t_pair.push_back(pair != 0);
            t_arrival.push_back(0);
        end
        $fclose(fd);
    endtask

    // One transaction from trace entry k, request through response
    task automatic run_txn(input int k);
        int m;
        int stall;
        logic wr_op;
        logic accepted;
        logic done;
        logic ok;
        logic [ID_W-1:0]   id;
        logic [ID_W-1:0]   got_id;
        logic [1:0]        got_resp;
        logic [DATA_W-1:0] got_data;
        m = t_master[k];
        wr_op = t_is_wr[k];
        // Fixed ID per master
        id = ID_W'(m + 1);
        ok = 1'b1;
        // Response back-pressure of 0 to 2 cycles
        stall = $urandom % 3;
        @(negedge clk);
        if (wr_op) begin
            wr_req[m] = '{id: id, addr: t_addr[k], data: t_wdata[k],
                          strb: t_strb[k], lock: t_lock[k]};
            wr_req_valid[m] = 1'b1;
        end else begin
            rd_req[m] = '{id: id, addr: t_addr[k], lock: t_lock[k]};
            rd_req_valid[m] = 1'b1;
        end
        // Request handshake, sampled before the edge updates anything
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = wr_op ? (wr_req_valid[m] && wr_req_ready[m])
                             : (rd_req_valid[m] && rd_req_ready[m]);
        end
        @(negedge clk);
        if (wr_op) begin
            wr_req_valid[m] = 1'b0;
        end else begin
            rd_req_valid[m] = 1'b0;
        end
        // Response due one cycle after acceptance
        @(posedge clk);
        if (!(wr_op ? wr_rsp_valid[m] : rd_rsp_valid[m])) begin
            $display("%s: response was not valid one cycle after the request", t_name[k]);
            err_cnt++;
            ok = 1'b0;
        end
        repeat (stall) @(posedge clk);
        @(negedge clk);
        if (wr_op) begin
            wr_rsp_ready[m] = 1'b1;
        end else begin
            rd_rsp_ready[m] = 1'b1;
        end
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = wr_op ? (wr_rsp_valid[m] && wr_rsp_ready[m])
                         : (rd_rsp_valid[m] && rd_rsp_ready[m]);
        end
        arrival_seq++;
        t_arrival[k] = arrival_seq;
        if (wr_op) begin
            got_id = wr_rsp[m].id;
            got_resp = wr_rsp[m].resp;
            got_data = '0;
        end else begin
            got_id = rd_rsp[m].id;
            got_resp = rd_rsp[m].resp;
            got_data = rd_rsp[m].data;
        end
        @(negedge clk);
        wr_rsp_ready[m] = 1'b0;
        rd_rsp_ready[m] = 1'b0;
        if (got_resp !== t_resp[k]) begin
            $display("CHECK FAILED %s response: expected %s, actual %s", t_name[k],
                     resp_name(t_resp[k]), resp_name(got_resp));
            err_cnt++;
            ok = 1'b0;
        end
        // Response carries the request ID back
        if (got_id !== id) begin
            $display("CHECK FAILED %s id: expected %h, actual %h", t_name[k], id, got_id);
            err_cnt++;
            ok = 1'b0;
        end
        // Read data only counts on OKAY and EXOKAY
        if (!wr_op && !t_resp[k][1] && got_data !== t_rdata[k]) begin
            $display("CHECK FAILED %s data: expected %h, actual %h", t_name[k],
                     t_rdata[k], got_data);
            err_cnt++;
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("%s: %s", t_name[k], ok ? "ok" : "failed");
    endtask

    // Run limit from the trace length
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, a transaction never completed", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int n;
        int k;
        int first_m;
        int prev_second;
        int sva_fails;
        logic prev_is_wr;
        void'($urandom(32'h47e2_4227));
        rst_n = 1'b0;
        rd_req_valid = '0;
        rd_rsp_ready = '0;
        wr_req_valid = '0;
        wr_rsp_ready = '0;
        rd_req[0] = '0;
        rd_req[1] = '0;
        wr_req[0] = '0;
        wr_req[1] = '0;
        load_trace();
        n = t_name.size();
        if (n == 0) begin
            $display("No trace lines were loaded");
            err_cnt++;
        end
        cycle_limit = n * 20 + 100;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        prev_second = -1;
        prev_is_wr = 1'b0;
        k = 0;
        while (k < n) begin
            if (t_pair[k] && (k + 1 >= n || t_master[k] == t_master[k + 1])) begin
                $display("Trace line %s is paired without a line for the other master",
                         t_name[k]);
                err_cnt++;
            end
            if (t_pair[k] && k + 1 < n && t_master[k] != t_master[k + 1]) begin
                fork
                    run_txn(k);
                    run_txn(k + 1);
                join
                first_m = (t_arrival[k] < t_arrival[k + 1]) ? t_master[k] : t_master[k + 1];
                // Same arbiter across a run of pairs, so service keeps alternating
                if (t_is_wr[k] == t_is_wr[k + 1]) begin
                    if (prev_second >= 0 && prev_is_wr == t_is_wr[k] &&
                        first_m == prev_second) begin
                        $display("CHECK FAILED %s order: expected master %0d, actual master %0d",
                                 t_name[k], 1 - prev_second, first_m);
                        err_cnt++;
                    end
                    prev_second = 1 - first_m;
                    prev_is_wr = t_is_wr[k];
                end else begin
                    prev_second = -1;
                end
                k += 2;
            end else begin
                run_txn(k);
                prev_second = -1;
                k += 1;
            end
        end
        sva_fails = i_excl_mem_top.i_monitor.i_sva.fail_cnt;
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertions failed",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt, sva_fails);
        if (err_cnt == 0 && sva_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== bench/excl_trace.txt ====
# name master op lock addr wdata strb exp_resp exp_rdata pair (hex: addr wdata strb rdata)
# resp 0 OKAY 1 EXOKAY 3 DECERR, pair 1 issues the line together with the next one
alias_init     0 wr 0 0000 01020304 f 0 00000000 0
plain_wr       0 wr 0 0010 aabbccdd f 0 00000000 0
plain_wr_strb  0 wr 0 0010 11223344 5 0 00000000 0
plain_rd       1 rd 0 0010 00000000 0 0 aa22cc44 0
ex_init_wr     0 wr 0 0020 00000005 f 0 00000000 0
ex_lr          0 rd 1 0020 00000000 0 1 00000005 0
ex_sc          0 wr 1 0020 00000006 f 1 00000000 0
ex_check       0 rd 0 0020 00000000 0 0 00000006 0
nores_sc       1 wr 1 0020 00000099 f 0 00000000 0
nores_check    1 rd 0 0020 00000000 0 0 00000006 0
diff_init_wr   1 wr 0 0024 12345678 f 0 00000000 0
diff_lr        1 rd 1 0020 00000000 0 1 00000006 0
diff_sc        1 wr 1 0024 87654321 f 0 00000000 0
diff_check     1 rd 0 0024 00000000 0 0 12345678 0
id_sc          0 wr 1 0020 000000aa f 0 00000000 0
id_check       1 rd 0 0020 00000000 0 0 00000006 0
race_init      0 wr 0 0030 00000100 f 0 00000000 0
race_lr        0 rd 1 0030 00000000 0 1 00000100 0
race_wr        1 wr 0 0030 00000200 f 0 00000000 0
race_sc        0 wr 1 0030 00000300 f 0 00000000 0
race_check     0 rd 0 0030 00000000 0 0 00000200 0
oor_wr         0 wr 0 0400 deadbeef f 3 00000000 0
oor_rd         1 rd 0 0400 00000000 0 3 00000000 0
oor_lr         0 rd 1 fffc 00000000 0 3 00000000 0
oor_sc         1 wr 1 fffc 00000001 f 3 00000000 0
alias_check    1 rd 0 0000 00000000 0 0 01020304 0
pair_wr_a      0 wr 0 0040 a0a0a0a0 f 0 00000000 1
pair_wr_b      1 wr 0 0044 b1b1b1b1 f 0 00000000 0
pair_rd_a      0 rd 0 0044 00000000 0 0 b1b1b1b1 1
pair_rd_b      1 rd 0 0040 00000000 0 0 a0a0a0a0 0
pair_rd_c      0 rd 0 0040 00000000 0 0 a0a0a0a0 1
pair_rd_d      1 rd 0 0044 00000000 0 0 b1b1b1b1 0
pair_rd_e      0 rd 0 0044 00000000 0 0 b1b1b1b1 1
pair_rd_f      1 rd 0 0040 00000000 0 0 a0a0a0a0 0
pair_mix_a     0 wr 0 0048 c3c3c3c3 f 0 00000000 1
pair_mix_b     1 rd 0 0040 00000000 0 0 a0a0a0a0 0

// ==== compile.f ====
hdl/excl_pkg.sv
hdl/txn_arbiter.sv
hdl/exclusive_monitor.sv
hdl/sram_target.sv
hdl/excl_mem_top.sv
bench/tb_clock_gen.sv
bench/excl_mem_sva.sv
bench/excl_mem_tb.sv

// ==== Bender.yml ====
package:
  name: excl_mem

sources:
  - hdl/excl_pkg.sv
  - hdl/txn_arbiter.sv
  - hdl/exclusive_monitor.sv
  - hdl/sram_target.sv
  - hdl/excl_mem_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/excl_mem_sva.sv
      - bench/excl_mem_tb.sv
